/* files.f */
hdl/eth_rx_pkg.sv
hdl/stream_skid_buffer.sv
hdl/eth_hdr_parser.sv
hdl/eth_rx_stats.sv
hdl/eth_rx_top.sv
test/eth_rx_checker.sv
test/eth_rx_tb.sv

/* Makefile */
SIM  := obj_dir/eth_rx_sim
SRCS := $(shell cat files.f)

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module eth_rx_tb \
		-f files.f --Mdir obj_dir -o eth_rx_sim

run: $(SIM)
	./$(SIM) | awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean

/* test/eth_rx_tb.sv */
// Testbench for the Ethernet receive path with a frame table, stream driver, random ready and APB
`default_nettype none

module eth_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [47:0] dest;
        logic [47:0] src;
        logic [15:0] etype;
        logic [7:0]  len;
        logic [7:0]  seed;
        logic        user;
        logic        bp;
    } frame_row_t;

    logic        clk;
    logic        rst;
    logic [7:0]  in_data;
    logic        in_valid;
    logic        in_ready;
    logic        in_last;
    logic        in_user;
    logic [47:0] hdr_dest_mac;
    logic [47:0] hdr_src_mac;
    logic [15:0] hdr_type;
    logic        hdr_valid;
    logic        hdr_ready;
    logic [7:0]  pay_data;
    logic        pay_valid;
    logic        pay_ready;
    logic        pay_last;
    logic        pay_user;
    logic        busy;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic        run_done;
    logic        report_done;
    logic        bp_mode;
    int          errors;
    int          checks;
    int          pending;
    int          tests_run;
    int          tests_bad;

    // rows of 14 bytes or less end inside the header
    frame_row_t rows [8] = '{
        '{48'h0011_2233_4455, 48'h0a0b_0c0d_0e0f, 16'h0800, 8'd64, 8'h10, 1'b0, 1'b0},
        '{48'hffff_ffff_ffff, 48'h0200_0000_0001, 16'h0806, 8'd20, 8'h80, 1'b1, 1'b0},
        '{48'h0102_0304_0506, 48'h1112_1314_1516, 16'h86dd, 8'd6,  8'h00, 1'b1, 1'b0},
        '{48'h3c5a_a5c3_0f01, 48'h7e81_18e7_4242, 16'h88cc, 8'd15, 8'hf0, 1'b0, 1'b1},
        '{48'hdead_beef_0001, 48'hcafe_f00d_0002, 16'h8100, 8'd14, 8'h00, 1'b0, 1'b1},
        '{48'h0250_56c0_0008, 48'h0250_56c0_0001, 16'h0800, 8'd40, 8'h33, 1'b1, 1'b1},
        '{48'h1234_5678_9abc, 48'hfedc_ba98_7654, 16'h0800, 8'd1,  8'h00, 1'b0, 1'b0},
        '{48'h00aa_bb00_ccdd, 48'h00ee_ff00_1122, 16'h88f7, 8'd30, 8'hc8, 1'b0, 1'b1}
    };

    eth_rx_top uut (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .in_last(in_last), .in_user(in_user),
        .hdr_dest_mac(hdr_dest_mac), .hdr_src_mac(hdr_src_mac), .hdr_type(hdr_type),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
        .pay_last(pay_last), .pay_user(pay_user),
        .busy(busy),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    eth_rx_checker chk (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .in_last(in_last), .in_user(in_user),
        .hdr_dest_mac(hdr_dest_mac), .hdr_src_mac(hdr_src_mac), .hdr_type(hdr_type),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .pay_data(pay_data), .pay_valid(pay_valid), .pay_ready(pay_ready),
        .pay_last(pay_last), .pay_user(pay_user),
        .busy(busy),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .run_done(run_done), .report_done(report_done),
        .errors(errors), .checks(checks), .pending(pending)
    );

    // byte i of a row takes the header fields most significant byte first and then seed plus i
    function automatic logic [7:0] frame_byte(input int r, input int i);
        if (i < 6) begin
            return rows[r].dest[8*(5 - i) +: 8];
        end else if (i < 12) begin
            return rows[r].src[8*(11 - i) +: 8];
        end else if (i < 14) begin
            return rows[r].etype[8*(13 - i) +: 8];
        end
        return rows[r].seed + 8'(i);
    endfunction

    function automatic int total_frame_bytes();
        int sum;
        sum = 0;
        for (int r = 0; r < $size(rows); r++) begin
            sum += int'(rows[r].len);
        end
        return sum;
    endfunction

    task automatic send_frame(input int r);
        int unsigned gap;
        logic        accepted;
        for (int i = 0; i < int'(rows[r].len); i++) begin
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
            in_valid = 1'b1;
            in_data  = frame_byte(r, i);
            in_last  = (i == int'(rows[r].len) - 1);
            in_user  = in_last && rows[r].user;
            // in_ready only changes on the rising edge, so it is stable here
            accepted = 1'b0;
            while (!accepted) begin
                accepted = in_ready;
                @(negedge clk);
            end
            in_valid = 1'b0;
            in_last  = 1'b0;
            in_user  = 1'b0;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        logic done;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        done    = 1'b0;
        while (!done) begin
            done = pready;
            @(negedge clk);
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // output readiness is random per cycle in back-pressure rows
    initial begin
        hdr_ready = 1'b0;
        pay_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (bp_mode) begin
                hdr_ready = ($urandom % 2) == 1;
                pay_ready = ($urandom % 2) == 1;
            end else begin
                hdr_ready = 1'b1;
                pay_ready = 1'b1;
            end
        end
    end

    initial begin
        int unsigned limit;
        limit = total_frame_bytes() * 20 + 1000;
        repeat (limit) @(posedge clk);
        $display("watchdog: run timed out after %0d cycles", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        int err_before;
        void'($urandom(32'h264906fb));
        rst       = 1'b1;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        in_user   = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        bp_mode   = 1'b0;
        run_done  = 1'b0;
        tests_run = 0;
        tests_bad = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        for (int r = 0; r < $size(rows); r++) begin
            err_before = errors;
            bp_mode    = rows[r].bp;
            send_frame(r);
            // the row is done once every expected item has come out
            while (pending != 0 || busy) @(negedge clk);
            report_test($sformatf("row %0d, %0d bytes, %s%s", r, rows[r].len,
                                  rows[r].len > 8'(eth_rx_pkg::hdr_len) ? "full" : "truncated",
                                  rows[r].bp ? ", back-pressure" : ""), err_before);
        end
        bp_mode = 1'b0;

        err_before = errors;
        apb_access(1'b0, eth_rx_pkg::reg_frames, '0);
        apb_access(1'b0, eth_rx_pkg::reg_hdr_errors, '0);
        apb_access(1'b0, eth_rx_pkg::reg_bad_frames, '0);
        report_test("counter reads", err_before);

        err_before = errors;
        apb_access(1'b1, eth_rx_pkg::reg_clear, 32'h1);
        apb_access(1'b0, eth_rx_pkg::reg_frames, '0);
        apb_access(1'b0, eth_rx_pkg::reg_hdr_errors, '0);
        apb_access(1'b0, eth_rx_pkg::reg_bad_frames, '0);
        report_test("counter clear", err_before);

        err_before = errors;
        apb_access(1'b0, 8'h10, '0);
        apb_access(1'b1, 8'h10, 32'h1);
        report_test("unmapped address", err_before);

        run_done = 1'b1;
        while (!report_done) @(negedge clk);
        $display("tests: %0d run, %0d with errors; checks: %0d, errors: %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/eth_rx_checker.sv */
// Scoreboard for the Ethernet receive path that rebuilds headers, payload and counts from the input
`default_nettype none

module eth_rx_checker (
    input  wire         clk,
    input  wire         rst,

    input  wire  [7:0]  in_data,
    input  wire         in_valid,
    input  wire         in_ready,
    input  wire         in_last,
    input  wire         in_user,

    input  wire  [47:0] hdr_dest_mac,
    input  wire  [47:0] hdr_src_mac,
    input  wire  [15:0] hdr_type,
    input  wire         hdr_valid,
    input  wire         hdr_ready,

    input  wire  [7:0]  pay_data,
    input  wire         pay_valid,
    input  wire         pay_ready,
    input  wire         pay_last,
    input  wire         pay_user,

    input  wire         busy,

    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    input  wire  [31:0] prdata,
    input  wire         pready,
    input  wire         pslverr,

    input  wire         run_done,
    output logic        report_done,
    output int          errors,
    output int          checks,
    output int          pending
);
    timeunit 1ns;
    timeprecision 1ps;

    // expected header words and payload beats {data, last, user}
    logic [111:0] hdr_q [$];
    logic [9:0]   pay_q [$];
    logic [111:0] hdr_acc;
    int           byte_idx;
    logic         check_idle;

    logic [eth_rx_pkg::stat_width-1:0] n_frames;
    logic [eth_rx_pkg::stat_width-1:0] n_trunc;
    logic [eth_rx_pkg::stat_width-1:0] n_bad;

    task automatic compare_value(input string what, input logic [111:0] got,
                                 input logic [111:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("checker at %0t ns: %s", $time, msg);
    endtask

    // a register read returns the count with no slave error
    task automatic compare_read(input string what, input logic [111:0] exp);
        compare_value(what, 112'(prdata), exp);
        compare_value({what, " pslverr"}, 112'(pslverr), '0);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            hdr_q.delete();
            pay_q.delete();
            hdr_acc     = '0;
            byte_idx    = 0;
            n_frames    = '0;
            n_trunc     = '0;
            n_bad       = '0;
            errors      = 0;
            checks      = 0;
            pending     = 0;
            report_done = 1'b0;
            check_idle  = 1'b1;
        end else begin
            if (check_idle) begin
                compare_value("in_ready, hdr_valid, pay_valid, pslverr after reset",
                              112'({in_ready, hdr_valid, pay_valid, pslverr}), '0);
                check_idle = 1'b0;
            end

            // a frame is in progress from its first byte until its last byte is taken
            compare_value("busy", 112'(busy), 112'(byte_idx != 0));

            // the first 14 bytes build the header and the rest is payload
            if (in_valid && in_ready) begin
                if (byte_idx < eth_rx_pkg::hdr_len) begin
                    hdr_acc = {hdr_acc[103:0], in_data};
                    if (in_last) begin
                        n_trunc++;
                    end else if (byte_idx == eth_rx_pkg::hdr_len - 1) begin
                        hdr_q.push_back(hdr_acc);
                        n_frames++;
                    end
                end else begin
                    pay_q.push_back({in_data, in_last, in_user});
                    if (in_last && in_user) begin
                        n_bad++;
                    end
                end
                byte_idx = in_last ? 0 : byte_idx + 1;
            end

            if (hdr_valid && hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    report_problem("a header came out without a complete header on the input");
                end else begin
                    compare_value("header {dest, src, type}",
                                  {hdr_dest_mac, hdr_src_mac, hdr_type}, hdr_q.pop_front());
                end
            end

            if (pay_valid && pay_ready) begin
                if (pay_q.size() == 0) begin
                    report_problem("a payload beat came out that no frame carried");
                end else begin
                    compare_value("payload {data, last, user}",
                                  112'({pay_data, pay_last, pay_user}), 112'(pay_q.pop_front()));
                end
            end

            if (psel && penable) begin
                compare_value("pready", 112'(pready), 112'(1));
                if (!(paddr inside {eth_rx_pkg::reg_frames, eth_rx_pkg::reg_hdr_errors,
                                    eth_rx_pkg::reg_bad_frames, eth_rx_pkg::reg_clear})) begin
                    compare_value("pslverr on unmapped address", 112'(pslverr), 112'(1));
                end else if (!pwrite && paddr == eth_rx_pkg::reg_frames) begin
                    compare_read("frame count", 112'(n_frames));
                end else if (!pwrite && paddr == eth_rx_pkg::reg_hdr_errors) begin
                    compare_read("header error count", 112'(n_trunc));
                end else if (!pwrite && paddr == eth_rx_pkg::reg_bad_frames) begin
                    compare_read("bad frame count", 112'(n_bad));
                end else if (pwrite && paddr == eth_rx_pkg::reg_clear) begin
                    compare_value("pslverr on clear", 112'(pslverr), '0);
                    if (pwdata[0]) begin
                        n_frames = '0;
                        n_trunc  = '0;
                        n_bad    = '0;
                    end
                end
            end

            if (run_done && !report_done) begin
                if (hdr_q.size() != 0) begin
                    report_problem($sformatf("%0d expected headers never came out", hdr_q.size()));
                end
                if (pay_q.size() != 0) begin
                    report_problem($sformatf("%0d payload bytes were never delivered",
                                             pay_q.size()));
                end
                if (byte_idx != 0) begin
                    report_problem("the input stream stopped in the middle of a frame");
                end
                report_done = 1'b1;
            end

            pending = hdr_q.size() + pay_q.size();
        end
    end

endmodule

`default_nettype wire

/* hdl/eth_rx_top.sv */
// Ethernet receive top: header parser, header and payload register slices, statistics
`default_nettype none

module eth_rx_top (
    input  wire         clk,
    input  wire         rst,

    input  wire  [7:0]  in_data,
    input  wire         in_valid,
    output logic        in_ready,
    input  wire         in_last,
    input  wire         in_user,

    output logic [47:0] hdr_dest_mac,
    output logic [47:0] hdr_src_mac,
    output logic [15:0] hdr_type,
    output logic        hdr_valid,
    input  wire         hdr_ready,

    output logic [7:0]  pay_data,
    output logic        pay_valid,
    input  wire         pay_ready,
    output logic        pay_last,
    output logic        pay_user,

    output logic        busy,

    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    eth_rx_pkg::eth_hdr_t  parser_hdr;
    logic                  parser_hdr_valid;
    logic                  parser_hdr_ready;
    eth_rx_pkg::eth_hdr_t  hdr_out;

    eth_rx_pkg::eth_beat_t beat;
    logic                  beat_valid;
    logic                  beat_ready;
    eth_rx_pkg::eth_beat_t pay_out;

    logic ev_frame;
    logic ev_hdr_error;
    logic ev_bad_frame;

    eth_hdr_parser u_parser (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_last      (in_last),
        .in_user      (in_user),
        .hdr_word     (parser_hdr),
        .hdr_valid    (parser_hdr_valid),
        .hdr_ready    (parser_hdr_ready),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready),
        .ev_frame     (ev_frame),
        .ev_hdr_error (ev_hdr_error),
        .ev_bad_frame (ev_bad_frame),
        .busy         (busy)
    );

    stream_skid_buffer #(.payload_t(eth_rx_pkg::eth_hdr_t)) u_hdr_slice (
        .clk       (clk),
        .rst       (rst),
        .in_item   (parser_hdr),
        .in_valid  (parser_hdr_valid),
        .in_ready  (parser_hdr_ready),
        .out_item  (hdr_out),
        .out_valid (hdr_valid),
        .out_ready (hdr_ready)
    );

    stream_skid_buffer #(.payload_t(eth_rx_pkg::eth_beat_t)) u_pay_slice (
        .clk       (clk),
        .rst       (rst),
        .in_item   (beat),
        .in_valid  (beat_valid),
        .in_ready  (beat_ready),
        .out_item  (pay_out),
        .out_valid (pay_valid),
        .out_ready (pay_ready)
    );

    eth_rx_stats u_stats (
        .clk          (clk),
        .rst          (rst),
        .ev_frame     (ev_frame),
        .ev_hdr_error (ev_hdr_error),
        .ev_bad_frame (ev_bad_frame),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    // header fields at the ports
    assign hdr_dest_mac = hdr_out.dest_mac;
    assign hdr_src_mac  = hdr_out.src_mac;
    assign hdr_type     = hdr_out.eth_type;

    assign pay_data = pay_out.data;
    assign pay_last = pay_out.last;
    assign pay_user = pay_out.user;

endmodule

`default_nettype wire

/* hdl/eth_rx_stats.sv */
// Receive statistics: saturating frame, header error and bad frame counters behind APB
`default_nettype none

module eth_rx_stats (
    input  wire         clk,
    input  wire         rst,

    input  wire         ev_frame,
    input  wire         ev_hdr_error,
    input  wire         ev_bad_frame,

    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [eth_rx_pkg::stat_width-1:0] counts [3];
    logic [2:0] events;
    logic       access;
    logic       rd_ok;
    logic       wr_ok;
    logic       clear;

    // counter order matches the register map
    assign events = {ev_bad_frame, ev_hdr_error, ev_frame};
    assign access = psel && penable;

    assign rd_ok = (paddr == eth_rx_pkg::reg_frames) ||
                   (paddr == eth_rx_pkg::reg_hdr_errors) ||
                   (paddr == eth_rx_pkg::reg_bad_frames);
    assign wr_ok = (paddr == eth_rx_pkg::reg_clear);

    assign clear   = access && pwrite && wr_ok && pwdata[0];
    assign pready  = 1'b1;
    assign pslverr = access && (pwrite ? !wr_ok : !rd_ok);

    always_comb begin
        case (paddr)
            eth_rx_pkg::reg_frames:     prdata = counts[0];
            eth_rx_pkg::reg_hdr_errors: prdata = counts[1];
            eth_rx_pkg::reg_bad_frames: prdata = counts[2];
            default:                    prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                counts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (clear) begin
                    counts[i] <= '0;
                end else if (events[i] && (counts[i] != '1)) begin
                    // hold at all ones
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("eth_rx_stats: penable without psel");

endmodule

`default_nettype wire

/* hdl/eth_hdr_parser.sv */
// Ethernet header parser: collects the 14 header bytes, forwards the payload, flags events
`default_nettype none

module eth_hdr_parser (
    input  wire                  clk,
    input  wire                  rst,

    input  wire  [7:0]           in_data,
    input  wire                  in_valid,
    output logic                 in_ready,
    input  wire                  in_last,
    input  wire                  in_user,

    output eth_rx_pkg::eth_hdr_t hdr_word,
    output logic                 hdr_valid,
    input  wire                  hdr_ready,

    output eth_rx_pkg::eth_beat_t beat,
    output logic                 beat_valid,
    input  wire                  beat_ready,

    output logic                 ev_frame,
    output logic                 ev_hdr_error,
    output logic                 ev_bad_frame,
    output logic                 busy
);

    localparam int cnt_w = $clog2(eth_rx_pkg::hdr_len + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_payload
    } state_t;

    state_t     state;
    logic [cnt_w-1:0] cnt;
    logic       hdr_free;
    logic       take;
    logic       hdr_byte;
    logic       hdr_cut;
    logic       hdr_done;
    logic       hdr_valid_next;

    assign take     = in_valid && in_ready;
    assign hdr_byte = take && (state != st_payload);
    // frame ended before a complete header
    assign hdr_cut  = hdr_byte && in_last;
    assign hdr_done = hdr_byte && !in_last && (cnt == cnt_w'(eth_rx_pkg::hdr_len - 1));

    // header stays offered until the slice takes it
    assign hdr_valid_next = (hdr_valid && !hdr_ready) || hdr_done;

    always_comb begin
        case (state)
            st_header:  in_ready = 1'b1;
            st_payload: in_ready = beat_ready;
            // a new frame waits for the previous header to leave
            default:    in_ready = hdr_free;
        endcase
    end

    // payload goes straight through
    assign beat       = '{data: in_data, last: in_last, user: in_user};
    assign beat_valid = in_valid && (state == st_payload);
    assign busy       = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= st_idle;
            cnt          <= '0;
            hdr_valid    <= 1'b0;
            hdr_free     <= 1'b0;
            ev_frame     <= 1'b0;
            ev_hdr_error <= 1'b0;
            ev_bad_frame <= 1'b0;
        end else begin
            hdr_valid    <= hdr_valid_next;
            hdr_free     <= !hdr_valid_next;
            ev_frame     <= hdr_done;
            ev_hdr_error <= hdr_cut;
            ev_bad_frame <= take && (state == st_payload) && in_last && in_user;

            case (state)
                st_idle, st_header: begin
                    if (take) begin
                        if (in_last) begin
                            state <= st_idle;
                            cnt   <= '0;
                        end else if (hdr_done) begin
                            state <= st_payload;
                            cnt   <= '0;
                        end else begin
                            state <= st_header;
                            cnt   <= cnt + 1'b1;
                        end
                    end
                end
                st_payload: begin
                    if (take && in_last) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // steer each header byte into its field, most significant byte first
    always_ff @(posedge clk) begin
        if (hdr_byte) begin
            if (int'(cnt) < 6) begin
                hdr_word.dest_mac[8*(5 - int'(cnt)) +: 8] <= in_data;
            end else if (int'(cnt) < 12) begin
                hdr_word.src_mac[8*(11 - int'(cnt)) +: 8] <= in_data;
            end else begin
                hdr_word.eth_type[8*(13 - int'(cnt)) +: 8] <= in_data;
            end
        end
    end

    a_events_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(ev_frame && ev_hdr_error)
    ) else $error("eth_hdr_parser: frame and header error in the same cycle");

    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst)
        int'(cnt) <= eth_rx_pkg::hdr_len
    ) else $error("eth_hdr_parser: header byte counter out of range");

endmodule

`default_nettype wire

/* hdl/stream_skid_buffer.sv */
// Register slice for a valid/ready stream, two entries deep, full throughput, any payload type
`default_nettype none

module stream_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  wire      clk,
    input  wire      rst,

    input  payload_t in_item,
    input  wire      in_valid,
    output logic     in_ready,

    output payload_t out_item,
    output logic     out_valid,
    input  wire      out_ready
);

    payload_t spare_item;
    logic     spare_valid;
    logic     spare_valid_next;
    logic     accept;
    logic     main_load;

    assign accept = in_valid && in_ready;

    // main register can take a new item when it is empty or being drained
    assign main_load = out_ready || !out_valid;

    always_comb begin
        spare_valid_next = spare_valid;
        if (main_load) begin
            // spare (if any) moves to main, so it is always free afterwards
            spare_valid_next = 1'b0;
        end else if (accept) begin
            spare_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            spare_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            spare_valid <= spare_valid_next;
            // registered ready, only looks at the spare slot
            in_ready    <= !spare_valid_next;
            if (main_load) begin
                out_valid <= spare_valid || accept;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (main_load) begin
            if (spare_valid) begin
                out_item <= spare_item;
            end else if (accept) begin
                out_item <= in_item;
            end
        end else if (accept) begin
            spare_item <= in_item;
        end
    end

    // a stalled output item must not change until it is taken
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_item)
    ) else $error("stream_skid_buffer: output item changed while stalled");

endmodule

`default_nettype wire

/* hdl/eth_rx_pkg.sv */
// Ethernet receive shared definitions: header layout, beat and header types, stats register map
`default_nettype none

package eth_rx_pkg;

    // bytes in front of the payload (dest mac, src mac, ethertype)
    localparam int hdr_len = 14;

    // statistics counter width
    localparam int stat_width = 32;

    // one byte of payload with its frame flags
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } eth_beat_t;

    // parsed header, first byte on the wire sits in the top bits
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // APB byte addresses of the statistics block
    localparam logic [7:0] reg_frames     = 8'h00;
    localparam logic [7:0] reg_hdr_errors = 8'h04;
    localparam logic [7:0] reg_bad_frames = 8'h08;
    // write with bit 0 set zeroes all counters
    localparam logic [7:0] reg_clear      = 8'h0C;

endpackage

`default_nettype wire
